// ==== include/xbar_cfg_cfg.svh ====
// Crossbar sizing and routing field, included by the packages and every RTL module
`ifndef XBAR_CFG_CFG_SVH
`define XBAR_CFG_CFG_SVH

//////////////////////////////////////////////////
// Port counts
//////////////////////////////////////////////////
`define XBAR_N_MASTER     4                       // Core-side request ports
`define XBAR_N_SLAVE      4                       // Peripheral ports, power of two

//////////////////////////////////////////////////
// Widths
//////////////////////////////////////////////////
`define XBAR_ADDR_WIDTH   32                      // Byte address from the cores
`define XBAR_DATA_WIDTH   32
`define XBAR_BE_WIDTH     (`XBAR_DATA_WIDTH/8)    // One enable per byte lane

//////////////////////////////////////////////////
// Slave select field inside the address
// Field width must match log2 of the slave count
//////////////////////////////////////////////////
`define XBAR_ROUTE_LSB    12
`define XBAR_ROUTE_MSB    13

`endif

// ==== hw/xbar_map_pkg.sv ====
// Address map types and helpers, referenced by scoped name from the decode and top level
`include "xbar_cfg_cfg.svh"

package xbar_map_pkg;

    // Slave index, log2 of the slave count
    localparam int unsigned SLAVE_IDX_W = $clog2(`XBAR_N_SLAVE);

    // Word address drops the byte offset
    localparam int unsigned WORD_LSB    = 2;
    localparam int unsigned WORD_ADDR_W = `XBAR_ADDR_WIDTH - WORD_LSB;

    typedef logic [SLAVE_IDX_W-1:0] slave_idx_t;   // Which peripheral port
    typedef logic [WORD_ADDR_W-1:0] word_addr_t;   // Address as seen by a slave

    // Routing field of a core address
    function automatic slave_idx_t route_idx(input logic [`XBAR_ADDR_WIDTH-1:0] addr);
        return addr[`XBAR_ROUTE_MSB:`XBAR_ROUTE_LSB];
    endfunction

    // Byte address to word address, bits 31:2
    function automatic word_addr_t word_addr(input logic [`XBAR_ADDR_WIDTH-1:0] addr);
        return addr[`XBAR_ADDR_WIDTH-1:WORD_LSB];
    endfunction

endpackage

// ==== hw/xbar_txn_pkg.sv ====
// Transaction types shared by arbiters, response routing and the testbench
`include "xbar_cfg_cfg.svh"

package xbar_txn_pkg;

    //////////////////////////////////////////////////
    // Request side
    //////////////////////////////////////////////////

    // One-hot tag of the issuing master, echoed by the slave
    typedef logic [`XBAR_N_MASTER-1:0] master_id_t;

    // Request direction, same encoding as data_wen on the bus
    typedef enum logic
    {
        STORE = 1'b0,       // Write with byte enables
        LOAD  = 1'b1        // Read full word
    } wen_t;

    //////////////////////////////////////////////////
    // Response side
    //////////////////////////////////////////////////

    // Response status, stores get one too
    typedef enum logic
    {
        OPC_OK  = 1'b0,
        OPC_ERR = 1'b1      // Slave rejected the access
    } opc_t;

endpackage

// ==== hw/xbar_addr_dec.sv ====
// Per-master decode stage: turns the core address into a one-hot slave request
`timescale 1ns/100ps
`include "xbar_cfg_cfg.svh"

module xbar_addr_dec
(
    input  logic                           clk,
    input  logic                           rst_i,           // Sync, active high

    // Core side
    input  logic                           data_req_i,      // Request from the core
    input  logic [`XBAR_ADDR_WIDTH-1:0]    data_add_i,      // Byte address
    output logic                           data_gnt_o,      // Grant back to the core

    // Toward the arbiters, one bit per slave
    output logic [`XBAR_N_SLAVE-1:0]       slave_req_o,
    input  logic [`XBAR_N_SLAVE-1:0]       slave_gnt_i
);

    localparam int unsigned N_SLAVE = `XBAR_N_SLAVE;

    xbar_map_pkg::slave_idx_t sel_idx;                      // Decoded target

    //////////////////////////////////////////////////
    // Address decode
    //////////////////////////////////////////////////

    assign sel_idx = xbar_map_pkg::route_idx(data_add_i);

    // Raise only the selected slave's line
    always_comb
    begin
        for (int s = 0; s < N_SLAVE; s++)
        begin
            slave_req_o[s] = data_req_i && (sel_idx == s);
        end
    end

    //////////////////////////////////////////////////
    // Grant fold back
    //////////////////////////////////////////////////

    // Arbiter grants are already qualified by our request,
    // masking with the request line keeps stray grants out
    assign data_gnt_o = |(slave_gnt_i & slave_req_o);

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // Exactly one target per live request
    a_req_onehot : assert property (
        @(posedge clk) disable iff (rst_i)
        data_req_i |-> $onehot(slave_req_o)
    ) else $error("xbar_addr_dec: request not one-hot");

    // Core keeps its request and target until granted
    a_req_hold : assert property (
        @(posedge clk) disable iff (rst_i)
        (data_req_i && !data_gnt_o) |=> (data_req_i && $stable(slave_req_o))
    ) else $error("xbar_addr_dec: request dropped or retargeted before grant");

endmodule

// ==== hw/xbar_req_arb.sv ====
// Per-slave execute stage: round-robin among requesting masters, muxes the winner to the slave
`timescale 1ns/100ps
`include "xbar_cfg_cfg.svh"

module xbar_req_arb
(
    input  logic                                              clk,
    input  logic                                              rst_i,

    // From the decoders, one entry per master
    input  logic [`XBAR_N_MASTER-1:0]                         mst_req_i,
    input  xbar_map_pkg::word_addr_t [`XBAR_N_MASTER-1:0]     mst_add_i,
    input  xbar_txn_pkg::wen_t [`XBAR_N_MASTER-1:0]           mst_wen_i,
    input  logic [`XBAR_N_MASTER-1:0][`XBAR_DATA_WIDTH-1:0]   mst_wdata_i,
    input  logic [`XBAR_N_MASTER-1:0][`XBAR_BE_WIDTH-1:0]     mst_be_i,
    output logic [`XBAR_N_MASTER-1:0]                         mst_gnt_o,      // Qualified grants

    // Slave port
    output logic                                              data_req_o,
    output xbar_map_pkg::word_addr_t                          data_add_o,
    output xbar_txn_pkg::wen_t                                data_wen_o,
    output logic [`XBAR_DATA_WIDTH-1:0]                       data_wdata_o,
    output logic [`XBAR_BE_WIDTH-1:0]                         data_be_o,
    output xbar_txn_pkg::master_id_t                          data_ID_o,      // Winner tag
    input  logic                                              data_gnt_i      // Slave accepts
);

    localparam int unsigned N_MASTER = `XBAR_N_MASTER;
    localparam int unsigned IDX_W    = (N_MASTER > 1) ? $clog2(N_MASTER) : 1;

    logic [IDX_W-1:0]          ptr_q;        // Highest priority master this cycle
    logic [IDX_W-1:0]          ptr_nxt;
    logic [IDX_W-1:0]          win_idx;      // Selected master
    logic                      win_found;    // Any master requesting
    xbar_txn_pkg::master_id_t  win_oh;       // Selected master, one-hot
    logic                      accept;       // Handshake with the slave

    //////////////////////////////////////////////////
    // Winner search, starting at the pointer
    //////////////////////////////////////////////////

    always_comb
    begin : win_search
        int unsigned cand;
        win_found = 1'b0;
        win_idx   = ptr_q;
        for (int unsigned i = 0; i < N_MASTER; i++)
        begin
            cand = (ptr_q + i) % N_MASTER;           // Wrap around the ring
            if (!win_found && mst_req_i[cand])
            begin
                win_found = 1'b1;
                win_idx   = cand[IDX_W-1:0];
            end
        end
    end

    // One-hot form, doubles as the ID
    always_comb
    begin
        for (int m = 0; m < N_MASTER; m++)
        begin
            win_oh[m] = win_found && (win_idx == m);
        end
    end

    //////////////////////////////////////////////////
    // Payload mux toward the slave
    //////////////////////////////////////////////////

    assign data_req_o   = win_found;
    assign data_add_o   = mst_add_i[win_idx];
    assign data_wen_o   = mst_wen_i[win_idx];
    assign data_wdata_o = mst_wdata_i[win_idx];
    assign data_be_o    = mst_be_i[win_idx];
    assign data_ID_o    = win_oh;

    // Grant only reaches the winner, and only with slave gnt
    assign mst_gnt_o = win_oh & {N_MASTER{data_gnt_i}};
    assign accept    = data_req_o && data_gnt_i;

    //////////////////////////////////////////////////
    // Round-robin pointer
    //////////////////////////////////////////////////

    // One past the winner
    assign ptr_nxt = (win_idx == N_MASTER - 1) ? '0 : win_idx + 1'b1;

    always_ff @(posedge clk)
    begin
        if (rst_i)
        begin
            ptr_q <= '0;                             // Master 0 first
        end
        else if (accept)
        begin
            ptr_q <= ptr_nxt;
        end
    end

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    a_gnt_onehot0 : assert property (
        @(posedge clk) disable iff (rst_i)
        $onehot0(mst_gnt_o)
    ) else $error("xbar_req_arb: more than one master granted");

    // A grant always lands on a live request
    a_gnt_has_req : assert property (
        @(posedge clk) disable iff (rst_i)
        (mst_gnt_o & ~mst_req_i) == '0
    ) else $error("xbar_req_arb: grant without request");

endmodule

// ==== hw/xbar_resp_route.sv ====
// Per-master result stage: selects the slave response whose ID carries this master's bit
`timescale 1ns/100ps
`include "xbar_cfg_cfg.svh"

module xbar_resp_route
#(
    parameter int unsigned MASTER_IDX = 0                    // Which ID bit is ours
)
(
    input  logic                                             clk,   // Checks only

    // Responses of all slaves
    input  logic [`XBAR_N_SLAVE-1:0]                         slv_r_valid_i,
    input  logic [`XBAR_N_SLAVE-1:0][`XBAR_DATA_WIDTH-1:0]   slv_r_rdata_i,
    input  xbar_txn_pkg::master_id_t [`XBAR_N_SLAVE-1:0]     slv_r_ID_i,     // Echoed tags
    input  xbar_txn_pkg::opc_t [`XBAR_N_SLAVE-1:0]           slv_r_opc_i,

    // Back to the core
    output logic                                             data_r_valid_o,
    output logic [`XBAR_DATA_WIDTH-1:0]                      data_r_rdata_o,
    output xbar_txn_pkg::opc_t                               data_r_opc_o
);

    localparam int unsigned N_SLAVE = `XBAR_N_SLAVE;

    logic [N_SLAVE-1:0]        hit;          // Slave answering this master
    xbar_map_pkg::slave_idx_t  hit_idx;      // Encoded form for the mux

    //////////////////////////////////////////////////
    // ID match
    //////////////////////////////////////////////////

    always_comb
    begin
        for (int s = 0; s < N_SLAVE; s++)
        begin
            hit[s] = slv_r_valid_i[s] && slv_r_ID_i[s][MASTER_IDX];
        end
    end

    // Encode the hit, at most one is expected
    always_comb
    begin
        hit_idx = '0;
        for (int s = 0; s < N_SLAVE; s++)
        begin
            if (hit[s])
            begin
                hit_idx = xbar_map_pkg::slave_idx_t'(s);
            end
        end
    end

    //////////////////////////////////////////////////
    // Response mux
    //////////////////////////////////////////////////

    assign data_r_valid_o = |hit;
    assign data_r_rdata_o = slv_r_rdata_i[hit_idx];  // Don't care when not valid
    assign data_r_opc_o   = slv_r_opc_i[hit_idx];

    //////////////////////////////////////////////////
    // Checks
    //////////////////////////////////////////////////

    // Slaves answer this core one at a time
    a_one_resp : assert property (
        @(posedge clk)
        $onehot0(hit)
    ) else $error("xbar_resp_route: two slaves answer master %0d", MASTER_IDX);

endmodule

// ==== hw/xbar_periph.sv ====
// Crossbar top level: wires decoders, per-slave arbiters and response routing between ports
`timescale 1ns/100ps
`include "xbar_cfg_cfg.svh"

module xbar_periph
(
    input  logic                                              clk,
    input  logic                                              rst_i,          // Sync, active high

    //////////////////////////////////////////////////
    // Master side
    //////////////////////////////////////////////////
    input  logic [`XBAR_N_MASTER-1:0]                         data_req_i,
    input  logic [`XBAR_N_MASTER-1:0][`XBAR_ADDR_WIDTH-1:0]   data_add_i,     // Byte address
    input  xbar_txn_pkg::wen_t [`XBAR_N_MASTER-1:0]           data_wen_i,     // 0 store, 1 load
    input  logic [`XBAR_N_MASTER-1:0][`XBAR_DATA_WIDTH-1:0]   data_wdata_i,
    input  logic [`XBAR_N_MASTER-1:0][`XBAR_BE_WIDTH-1:0]     data_be_i,
    output logic [`XBAR_N_MASTER-1:0]                         data_gnt_o,
    output logic [`XBAR_N_MASTER-1:0]                         data_r_valid_o,
    output logic [`XBAR_N_MASTER-1:0][`XBAR_DATA_WIDTH-1:0]   data_r_rdata_o,
    output xbar_txn_pkg::opc_t [`XBAR_N_MASTER-1:0]           data_r_opc_o,

    //////////////////////////////////////////////////
    // Slave side
    //////////////////////////////////////////////////
    output logic [`XBAR_N_SLAVE-1:0]                          data_req_o,
    output xbar_map_pkg::word_addr_t [`XBAR_N_SLAVE-1:0]      data_add_o,     // Word address
    output xbar_txn_pkg::wen_t [`XBAR_N_SLAVE-1:0]            data_wen_o,
    output logic [`XBAR_N_SLAVE-1:0][`XBAR_DATA_WIDTH-1:0]    data_wdata_o,
    output logic [`XBAR_N_SLAVE-1:0][`XBAR_BE_WIDTH-1:0]      data_be_o,
    output xbar_txn_pkg::master_id_t [`XBAR_N_SLAVE-1:0]      data_ID_o,
    input  logic [`XBAR_N_SLAVE-1:0]                          data_gnt_i,
    input  logic [`XBAR_N_SLAVE-1:0]                          data_r_valid_i,
    input  logic [`XBAR_N_SLAVE-1:0][`XBAR_DATA_WIDTH-1:0]    data_r_rdata_i,
    input  xbar_txn_pkg::master_id_t [`XBAR_N_SLAVE-1:0]      data_r_ID_i,    // Echoed tag
    input  xbar_txn_pkg::opc_t [`XBAR_N_SLAVE-1:0]            data_r_opc_i
);

    localparam int unsigned N_MASTER = `XBAR_N_MASTER;
    localparam int unsigned N_SLAVE  = `XBAR_N_SLAVE;

    xbar_map_pkg::word_addr_t [N_MASTER-1:0]  word_add;       // Offset dropped

    logic [N_MASTER-1:0][N_SLAVE-1:0]  req_from_mst;          // Decoder rows
    logic [N_SLAVE-1:0][N_MASTER-1:0]  req_to_slv;            // Arbiter rows
    logic [N_SLAVE-1:0][N_MASTER-1:0]  gnt_from_slv;          // Arbiter rows
    logic [N_MASTER-1:0][N_SLAVE-1:0]  gnt_to_mst;            // Decoder rows

    // Transpose request and grant matrices
    for (genvar m = 0; m < N_MASTER; m++)
    begin : g_xpose_m
        assign word_add[m] = xbar_map_pkg::word_addr(data_add_i[m]);
        for (genvar s = 0; s < N_SLAVE; s++)
        begin : g_xpose_s
            assign req_to_slv[s][m] = req_from_mst[m][s];
            assign gnt_to_mst[m][s] = gnt_from_slv[s][m];
        end
    end

    //////////////////////////////////////////////////
    // Decode and result, one each per master
    //////////////////////////////////////////////////
    for (genvar m = 0; m < N_MASTER; m++)
    begin : g_master
        xbar_addr_dec u_addr_dec
        (
            .clk         ( clk             ),
            .rst_i       ( rst_i           ),
            .data_req_i  ( data_req_i[m]   ),
            .data_add_i  ( data_add_i[m]   ),
            .data_gnt_o  ( data_gnt_o[m]   ),
            .slave_req_o ( req_from_mst[m] ),
            .slave_gnt_i ( gnt_to_mst[m]   )
        );

        xbar_resp_route #(.MASTER_IDX(m)) u_resp_route
        (
            .clk            ( clk               ),
            .slv_r_valid_i  ( data_r_valid_i    ),
            .slv_r_rdata_i  ( data_r_rdata_i    ),
            .slv_r_ID_i     ( data_r_ID_i       ),
            .slv_r_opc_i    ( data_r_opc_i      ),
            .data_r_valid_o ( data_r_valid_o[m] ),
            .data_r_rdata_o ( data_r_rdata_o[m] ),
            .data_r_opc_o   ( data_r_opc_o[m]   )
        );
    end

    //////////////////////////////////////////////////
    // Execute, one arbiter per slave
    //////////////////////////////////////////////////
    for (genvar s = 0; s < N_SLAVE; s++)
    begin : g_slave
        xbar_req_arb u_req_arb
        (
            .clk          ( clk             ),
            .rst_i        ( rst_i           ),
            .mst_req_i    ( req_to_slv[s]   ),
            .mst_add_i    ( word_add        ),
            .mst_wen_i    ( data_wen_i      ),
            .mst_wdata_i  ( data_wdata_i    ),
            .mst_be_i     ( data_be_i       ),
            .mst_gnt_o    ( gnt_from_slv[s] ),
            .data_req_o   ( data_req_o[s]   ),
            .data_add_o   ( data_add_o[s]   ),
            .data_wen_o   ( data_wen_o[s]   ),
            .data_wdata_o ( data_wdata_o[s] ),
            .data_be_o    ( data_be_o[s]    ),
            .data_ID_o    ( data_ID_o[s]    ),
            .data_gnt_i   ( data_gnt_i[s]   )
        );
    end

endmodule

// ==== verif/tb_xbar_periph.sv ====
// Crossbar testbench: runs file-driven master traffic against four slave memory models
`timescale 1ns/100ps
`include "xbar_cfg_cfg.svh"

module tb_xbar_periph;

    localparam int N_MASTER  = `XBAR_N_MASTER;
    localparam int N_SLAVE   = `XBAR_N_SLAVE;
    localparam int MAX_TXN   = 64;
    localparam int MEM_WORDS = 16;                          // Words per slave model
    localparam int PAY_W     = `XBAR_ADDR_WIDTH - 2 + 1 + `XBAR_DATA_WIDTH
                               + `XBAR_BE_WIDTH + N_MASTER;
    localparam int S_IDLE    = 0;
    localparam int S_REQ     = 1;                           // Waiting for gnt
    localparam int S_RESP    = 2;                           // Waiting for r_valid

    logic                                       clk;
    logic                                       rst_i;
    logic [N_MASTER-1:0]                        data_req_i;
    logic [N_MASTER-1:0][`XBAR_ADDR_WIDTH-1:0]  data_add_i;
    xbar_txn_pkg::wen_t [N_MASTER-1:0]          data_wen_i;
    logic [N_MASTER-1:0][`XBAR_DATA_WIDTH-1:0]  data_wdata_i;
    logic [N_MASTER-1:0][`XBAR_BE_WIDTH-1:0]    data_be_i;
    logic [N_MASTER-1:0]                        data_gnt_o;
    logic [N_MASTER-1:0]                        data_r_valid_o;
    logic [N_MASTER-1:0][`XBAR_DATA_WIDTH-1:0]  data_r_rdata_o;
    xbar_txn_pkg::opc_t [N_MASTER-1:0]          data_r_opc_o;
    logic [N_SLAVE-1:0]                         data_req_o;
    xbar_map_pkg::word_addr_t [N_SLAVE-1:0]     data_add_o;
    xbar_txn_pkg::wen_t [N_SLAVE-1:0]           data_wen_o;
    logic [N_SLAVE-1:0][`XBAR_DATA_WIDTH-1:0]   data_wdata_o;
    logic [N_SLAVE-1:0][`XBAR_BE_WIDTH-1:0]     data_be_o;
    xbar_txn_pkg::master_id_t [N_SLAVE-1:0]     data_ID_o;
    logic [N_SLAVE-1:0]                         data_gnt_i;
    logic [N_SLAVE-1:0]                         data_r_valid_i;
    logic [N_SLAVE-1:0][`XBAR_DATA_WIDTH-1:0]   data_r_rdata_i;
    xbar_txn_pkg::master_id_t [N_SLAVE-1:0]     data_r_ID_i;
    xbar_txn_pkg::opc_t [N_SLAVE-1:0]           data_r_opc_i;

    // Transaction table from the input file
    int          t_grp [MAX_TXN];
    int          t_mst [MAX_TXN];
    logic        t_load [MAX_TXN];
    logic [31:0] t_add [MAX_TXN];
    logic [31:0] t_wdata [MAX_TXN];
    logic [3:0]  t_be [MAX_TXN];
    logic [31:0] t_rdata [MAX_TXN];
    logic        t_opc [MAX_TXN];
    int          n_txn;

    int          mstate [N_MASTER];                        // Driver state per master
    int          cur [N_MASTER];                           // Current transaction index
    int          rr_ptr [N_SLAVE];                         // Expected round-robin pointer
    logic [31:0] mem [N_SLAVE][MEM_WORDS];
    logic        acc_v [N_SLAVE];                          // Accepted last cycle
    logic [PAY_W-1:0] acc_pay [N_SLAVE];
    logic        stall_v [N_SLAVE];                        // Request held off last cycle
    logic [PAY_W-1:0] stall_pay [N_SLAVE];
    logic [N_MASTER-1:0] stall_mask [N_SLAVE];
    int          errs = 0;
    int          busy = 0;
    int          done_cnt = 0;
    int          cycles = 0;
    int          limit = 0;

    xbar_periph u_xbar_periph (.*);

    initial
    begin
        clk = 1'b0;
        forever #10 clk = ~clk;                            // 20 ns period
    end

    task automatic flag_error(input string msg);
        errs++;
        $display("ERROR %0t: %s", $time, msg);
    endtask

    task automatic read_stimulus();
        int fd;
        string line;
        int g, m, op, opc;
        logic [31:0] a, wd, rd;
        logic [3:0] be;
        n_txn = 0;
        fd = $fopen("verif/xbar_input.txt", "r");
        if (fd == 0)
        begin
            errs++;
            $display("Could not open the stimulus file verif/xbar_input.txt");
            return;
        end
        while (!$feof(fd) && n_txn < MAX_TXN)
        begin
            line = "";
            void'($fgets(line, fd));
            if (line.len() > 1 && line.getc(0) != "#"
                && $sscanf(line, "%d %d %d %h %h %h %h %d", g, m, op, a, wd, be, rd, opc) == 8)
            begin
                t_grp[n_txn]   = g;
                t_mst[n_txn]   = m;
                t_load[n_txn]  = (op != 0);
                t_add[n_txn]   = a;
                t_wdata[n_txn] = wd;
                t_be[n_txn]    = be;
                t_rdata[n_txn] = rd;
                t_opc[n_txn]   = (opc != 0);
                n_txn++;
            end
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////////////////
    // Slave models and master drivers, 2 ns after the edge
    ////////////////////////////////////////////////////
    task automatic drive_inputs();
        int unsigned idx;
        int i;
        for (int s = 0; s < N_SLAVE; s++)
        begin
            idx = acc_pay[s][PAY_W-21 -: 10];              // Word address mod 1024
            data_r_valid_i[s] = acc_v[s];
            data_r_ID_i[s]    = acc_pay[s][N_MASTER-1:0];  // Echo the ID
            data_r_rdata_i[s] = '0;
            data_r_opc_i[s]   = xbar_txn_pkg::OPC_OK;
            if (acc_v[s] && idx >= MEM_WORDS)
                data_r_opc_i[s] = xbar_txn_pkg::OPC_ERR;
            else if (acc_v[s] && acc_pay[s][PAY_W-31])     // Load
                data_r_rdata_i[s] = mem[s][idx];
            else if (acc_v[s])
            begin
                for (int b = 0; b < `XBAR_BE_WIDTH; b++)
                begin
                    if (acc_pay[s][N_MASTER + b])
                        mem[s][idx][8*b +: 8] = acc_pay[s][N_MASTER + `XBAR_BE_WIDTH + 8*b +: 8];
                end
            end
            data_gnt_i[s] = ($urandom_range(3) != 0);      // About 75% ready
        end
        for (int m = 0; m < N_MASTER; m++)
        begin
            i = cur[m];
            data_req_i[m] = (mstate[m] == S_REQ);
            if (mstate[m] == S_REQ)
            begin
                data_add_i[m]   = t_add[i];
                data_wen_i[m]   = t_load[i] ? xbar_txn_pkg::LOAD : xbar_txn_pkg::STORE;
                data_wdata_i[m] = t_wdata[i];
                data_be_i[m]    = t_be[i];
            end
        end
    endtask

    ////////////////////////////////////////////////////
    // Checks at the falling edge, all inputs settled
    ////////////////////////////////////////////////////
    task automatic check_outputs();
        logic [N_MASTER-1:0] req_mask [N_SLAVE];
        logic [N_MASTER-1:0] win_mask [N_SLAVE];           // Expected winner per slave
        logic [PAY_W-1:0] pay;
        int tgt, w, i, c, win;
        logic exp_v;
        for (int s = 0; s < N_SLAVE; s++)
            req_mask[s] = '0;
        for (int m = 0; m < N_MASTER; m++)
        begin
            if (data_req_i[m])
                req_mask[data_add_i[m][`XBAR_ROUTE_MSB:`XBAR_ROUTE_LSB]][m] = 1'b1;
        end
        for (int s = 0; s < N_SLAVE; s++)
        begin
            // First requester at or after the pointer
            win         = -1;
            win_mask[s] = '0;
            for (int k = 0; k < N_MASTER; k++)
            begin
                c = (rr_ptr[s] + k) % N_MASTER;
                if (win < 0 && req_mask[s][c])
                    win = c;
            end
            if (win >= 0)
                win_mask[s][win] = 1'b1;
            pay = {data_add_o[s], data_wen_o[s], data_wdata_o[s], data_be_o[s], data_ID_o[s]};
            if (data_req_o[s] != (req_mask[s] != '0))
                flag_error($sformatf("slave %0d req %b, routed requests %b", s, data_req_o[s],
                                     req_mask[s]));
            if (data_req_o[s] && data_ID_o[s] != win_mask[s])
                flag_error($sformatf("slave %0d ID %b, round-robin winner %b", s,
                                     data_ID_o[s], win_mask[s]));
            else if (data_req_o[s])
            begin
                w = $clog2(data_ID_o[s]);
                if (pay[PAY_W-1:N_MASTER] != {data_add_i[w][31:2], data_wen_i[w], data_wdata_i[w],
                                              data_be_i[w]})
                    flag_error($sformatf("slave %0d payload differs from master %0d", s, w));
            end
            if (stall_v[s] && req_mask[s] == stall_mask[s] && pay != stall_pay[s])
                flag_error($sformatf("slave %0d payload changed under back-pressure", s));
            stall_v[s]    = data_req_o[s] && !data_gnt_i[s];
            stall_mask[s] = req_mask[s];
            stall_pay[s]  = pay;
            acc_v[s]      = data_req_o[s] && data_gnt_i[s];
            acc_pay[s]    = pay;
            if (win >= 0 && data_gnt_i[s])
                rr_ptr[s] = (win + 1) % N_MASTER;          // One past the accepted master
        end
        for (int m = 0; m < N_MASTER; m++)
        begin
            tgt   = data_add_i[m][`XBAR_ROUTE_MSB:`XBAR_ROUTE_LSB];
            i     = cur[m];
            exp_v = 1'b0;
            for (int s = 0; s < N_SLAVE; s++)
                exp_v |= data_r_valid_i[s] && data_r_ID_i[s][m];
            if (data_r_valid_o[m] != exp_v)
                flag_error($sformatf("master %0d r_valid %b, expected %b", m, data_r_valid_o[m],
                                     exp_v));
            if (data_r_valid_o[m] && mstate[m] != S_RESP)
                flag_error($sformatf("master %0d got a response with nothing in flight", m));
            else if (data_r_valid_o[m])
            begin
                if (data_r_opc_o[m] != t_opc[i])
                    flag_error($sformatf("txn %0d opc %b, expected %b", i, data_r_opc_o[m],
                                         t_opc[i]));
                if (t_load[i] && data_r_rdata_o[m] != t_rdata[i])
                    flag_error($sformatf("txn %0d rdata %h, expected %h", i, data_r_rdata_o[m],
                                         t_rdata[i]));
                mstate[m] = S_IDLE;
                busy--;
                done_cnt++;
            end
            // Grant only to the expected winner while its slave is ready
            if (data_gnt_o[m] != (data_req_i[m] && data_gnt_i[tgt] && win_mask[tgt][m]))
                flag_error($sformatf("master %0d gnt %b, slave %0d gnt %b", m, data_gnt_o[m], tgt,
                                     data_gnt_i[tgt]));
            if (data_req_i[m] && data_gnt_o[m])
                mstate[m] = S_RESP;
        end
    endtask

    task automatic run_cycle();
        @(posedge clk);
        #2;
        drive_inputs();
        @(negedge clk);
        check_outputs();
    endtask

    initial
    begin : main
        int pos;
        int grp;
        int m;
        rst_i          = 1'b1;
        data_req_i     = '0;
        data_add_i     = '0;
        data_wdata_i   = '0;
        data_be_i      = '0;
        data_gnt_i     = '0;
        data_r_valid_i = '0;
        data_r_rdata_i = '0;
        data_r_ID_i    = '0;
        for (int s = 0; s < N_SLAVE; s++)
        begin
            data_r_opc_i[s] = xbar_txn_pkg::OPC_OK;
            acc_v[s]   = 1'b0;
            stall_v[s] = 1'b0;
            rr_ptr[s]  = 0;                                // Master 0 first after reset
            for (int w = 0; w < MEM_WORDS; w++)
                mem[s][w] = 32'hA500_0000 | (s << 8) | w;   // Slave and word in every fill
        end
        for (int k = 0; k < N_MASTER; k++)
        begin
            data_wen_i[k] = xbar_txn_pkg::STORE;
            mstate[k] = S_IDLE;
            cur[k]    = 0;
        end
        void'($urandom(32'hae72));
        read_stimulus();
        limit = 40 * n_txn + 100;
        repeat (3) @(posedge clk);
        #2;
        rst_i = 1'b0;
        pos = 0;
        while (pos < n_txn)
        begin
            grp = t_grp[pos];
            while (pos < n_txn && t_grp[pos] == grp)       // Start the whole group together
            begin
                m = t_mst[pos];
                if (m < 0 || m >= N_MASTER || mstate[m] != S_IDLE)
                begin
                    errs++;
                    $display("Input line %0d has a bad or repeated master in group %0d", pos, grp);
                end
                else
                begin
                    cur[m]    = pos;
                    mstate[m] = S_REQ;
                    busy++;
                end
                pos++;
            end
            while (busy > 0)
                run_cycle();
        end
        run_cycle();                                       // Bus must stay quiet when idle
        $display("Summary: %0d of %0d transactions done, %0d errors", done_cnt, n_txn, errs);
        if (errs == 0 && n_txn > 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    initial
    begin : watchdog
        wait (limit > 0);
        while (cycles < limit)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, %0d of %0d transactions done", cycles, done_cnt,
                 n_txn);
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== xbar_periph.f ====
+incdir+include
hw/xbar_map_pkg.sv
hw/xbar_txn_pkg.sv
hw/xbar_addr_dec.sv
hw/xbar_req_arb.sv
hw/xbar_resp_route.sv
hw/xbar_periph.sv
verif/tb_xbar_periph.sv

// ==== verif/xbar_input.txt ====
# group master op(0 store, 1 load) addr wdata be exp_rdata exp_opc(0 ok, 1 err), all but group/master/op/opc in hex
# Slave memory starts as A500_0000 | slave << 8 | word, a group starts once the previous one has fully answered
0 0 0 00000000 11223344 f 00000000 0
0 1 0 00001004 55667788 f 00000000 0
0 2 0 40002008 99aabbcc f 00000000 0
0 3 0 0000300c ddeeff00 f 00000000 0
1 0 1 00001004 00000000 f 55667788 0
1 1 1 40002008 00000000 f 99aabbcc 0
1 2 1 0000300c 00000000 f ddeeff00 0
1 3 1 80000000 00000000 f 11223344 0
2 0 0 00001010 00000a0a f 00000000 0
2 1 0 00001014 00000b0b f 00000000 0
2 2 0 00001018 00000c0c f 00000000 0
2 3 0 0000101c 00000d0d f 00000000 0
3 0 1 0000101c 00000000 f 00000d0d 0
3 1 1 00001018 00000000 f 00000c0c 0
3 2 1 00001014 00000000 f 00000b0b 0
3 3 1 00001010 00000000 f 00000a0a 0
4 0 0 00003004 aabbccdd 1 00000000 0
4 1 0 00002020 12345678 c 00000000 0
4 2 0 00000040 ffffffff f 00000000 1
4 3 0 00001030 cafebabe 6 00000000 0
5 0 1 00003004 00000000 f a50003dd 0
5 1 1 00002020 00000000 f 12340208 0
5 2 1 00000040 00000000 f 00000000 1
5 3 1 00001030 00000000 f a5feba0c 0
6 0 1 00002080 00000000 f 00000000 1
6 1 1 00003ffc 00000000 f 00000000 1
6 2 1 0000303c 00000000 f a500030f 0
6 3 1 00000004 00000000 f a5000001 0
7 0 0 00003004 77000000 8 00000000 0
7 1 0 00002020 0000beef 3 00000000 0
7 2 0 00001034 01020304 0 00000000 0
7 3 1 0000300c 00000000 f ddeeff00 0
8 0 1 00002020 00000000 f 1234beef 0
8 1 1 00003004 00000000 f 770003dd 0
8 2 1 00001034 00000000 f a500010d 0
8 3 1 00000000 00000000 f 11223344 0
